//--- trs80_io_pkg.sv
package trs80_io_pkg;

   // data path widths
   localparam int BYTE_W       = 8;
   localparam int HIRES_ADDR_W = 15;   // 128 x 256 bytes of graphics RAM

   // port addresses
   localparam logic [7:0] ADDR_ORCH_L     = 8'h75;
   localparam logic [7:0] ADDR_ORCH_R     = 8'h79;
   localparam logic [7:0] ADDR_HIRES_BASE = 8'h80;   // 80-83
   localparam logic [7:0] ADDR_OPREG_BASE = 8'h84;   // 84-87
   localparam logic [7:0] ADDR_INT_BASE   = 8'he0;   // e0-e3
   localparam logic [7:0] ADDR_MOD_BASE   = 8'hec;   // ec-ef
   localparam logic [7:0] ADDR_CASS_BASE  = 8'hfc;   // fc-ff

   // mode register bits
   localparam int MOD_CPUFAST = 6;

   // hi-res options register bits
   localparam int OPT_GRAPHICS  = 0;
   localparam int OPT_X_DEC     = 2;
   localparam int OPT_Y_DEC     = 3;
   localparam int OPT_X_RD_HOLD = 4;
   localparam int OPT_Y_RD_HOLD = 5;
   localparam int OPT_X_WR_HOLD = 6;
   localparam int OPT_Y_WR_HOLD = 7;

   // interrupt status, rtc position
   localparam int INT_RTC_BIT = 2;

   // rtc periods in z80_clk cycles, scaled down for simulation
   localparam logic [7:0] RTC_PERIOD_SLOW = 8'd50;
   localparam logic [7:0] RTC_PERIOD_FAST = 8'd25;

   typedef enum logic [3:0] {
      PORT_NONE       = 4'd0,
      PORT_ORCH_L     = 4'd1,
      PORT_ORCH_R     = 4'd2,
      PORT_HIRES_X    = 4'd3,
      PORT_HIRES_Y    = 4'd4,
      PORT_HIRES_DATA = 4'd5,
      PORT_HIRES_OPT  = 4'd6,
      PORT_OPREG      = 4'd7,
      PORT_INT        = 4'd8,    // e0-e3
      PORT_MOD_RTC    = 4'd9,    // ec-ef
      PORT_CASS       = 4'd10    // fc-ff
   } io_port_t;

   typedef enum logic [1:0] {
      HIRES_IDLE    = 2'd0,
      HIRES_RD_PEND = 2'd1,
      HIRES_WR_PEND = 2'd2
   } hires_state_t;

endpackage

//--- z80_io_if.sv
`timescale 1ns/1ns

// decoded i/o access, one bus unit to many peripherals
interface z80_io_if;

   trs80_io_pkg::io_port_t port;   // PORT_NONE when no strobe
   logic [1:0] sub;                 // low address bits
   logic [trs80_io_pkg::BYTE_W-1:0] wdata;
   logic rd;                        // iorq_n and rd_n low
   logic wr;                        // iorq_n and wr_n low

   modport bus (
      output port, sub, wdata, rd, wr
   );

   modport periph (
      input port, sub, wdata, rd, wr
   );

endinterface

//--- z80_io_bus.sv
`timescale 1ns/1ns

module z80_io_bus (
   input  logic iorq_n,
   input  logic rd_n,
   input  logic wr_n,
   input  logic [7:0] io_addr,
   input  logic [trs80_io_pkg::BYTE_W-1:0] io_wdata,
   input  logic [trs80_io_pkg::BYTE_W-1:0] sys_rdata,
   input  logic [trs80_io_pkg::BYTE_W-1:0] hires_rdata,
   output logic [trs80_io_pkg::BYTE_W-1:0] io_rdata,
   z80_io_if.bus bus
);

   assign bus.rd    = ~iorq_n & ~rd_n;
   assign bus.wr    = ~iorq_n & ~wr_n;
   assign bus.sub   = io_addr[1:0];
   assign bus.wdata = io_wdata;

   // range decode, only while a strobe is active
   always_comb
   begin
      bus.port = trs80_io_pkg::PORT_NONE;
      if (bus.rd | bus.wr)
      begin
         if (io_addr == trs80_io_pkg::ADDR_ORCH_L)
            bus.port = trs80_io_pkg::PORT_ORCH_L;
         else if (io_addr == trs80_io_pkg::ADDR_ORCH_R)
            bus.port = trs80_io_pkg::PORT_ORCH_R;
         else if (io_addr[7:2] == trs80_io_pkg::ADDR_HIRES_BASE[7:2])
         begin
            case (bus.sub)   // hi-res board sub-ports
               2'd0:    bus.port = trs80_io_pkg::PORT_HIRES_X;
               2'd1:    bus.port = trs80_io_pkg::PORT_HIRES_Y;
               2'd2:    bus.port = trs80_io_pkg::PORT_HIRES_DATA;
               default: bus.port = trs80_io_pkg::PORT_HIRES_OPT;
            endcase
         end
         else if (io_addr[7:2] == trs80_io_pkg::ADDR_OPREG_BASE[7:2])
            bus.port = trs80_io_pkg::PORT_OPREG;
         else if (io_addr[7:2] == trs80_io_pkg::ADDR_INT_BASE[7:2])
            bus.port = trs80_io_pkg::PORT_INT;
         else if (io_addr[7:2] == trs80_io_pkg::ADDR_MOD_BASE[7:2])
            bus.port = trs80_io_pkg::PORT_MOD_RTC;
         else if (io_addr[7:2] == trs80_io_pkg::ADDR_CASS_BASE[7:2])
            bus.port = trs80_io_pkg::PORT_CASS;
      end
   end

   // read merge, idle bus floats high
   always_comb
   begin
      io_rdata = 8'hff;
      if (bus.rd)
      begin
         case (bus.port)
            trs80_io_pkg::PORT_HIRES_DATA: io_rdata = hires_rdata;
            trs80_io_pkg::PORT_OPREG,
            trs80_io_pkg::PORT_INT,
            trs80_io_pkg::PORT_MOD_RTC,
            trs80_io_pkg::PORT_CASS:       io_rdata = sys_rdata;
            default:                       io_rdata = 8'hff;   // no reader
         endcase
      end
   end

endmodule

//--- system_ctrl_regs.sv
`timescale 1ns/1ns

module system_ctrl_regs (
   input  logic z80_clk,
   input  logic z80_rst_n,
   input  logic rtc_tick,
   input  logic cass_in,
   z80_io_if.periph bus,
   output logic [trs80_io_pkg::BYTE_W-1:0] sys_rdata,
   output logic int_n,
   output logic cpu_fast,
   output logic cass_out_sel,
   output logic [1:0] cass_out
);

   logic [7:0] int_mask;   // e0-e3
   logic [7:0] mod_reg;    // ec-ef
   logic [7:0] cass_reg;   // fc-ff
   logic rtc_int;          // pending rtc interrupt
   logic [7:0] int_stat;   // active low status

   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
      begin
         int_mask <= 8'h00;
         mod_reg  <= 8'h00;
         cass_reg <= 8'h00;
      end
      else if (bus.wr)
      begin
         case (bus.port)
            trs80_io_pkg::PORT_INT:     int_mask <= bus.wdata;
            trs80_io_pkg::PORT_MOD_RTC: mod_reg  <= bus.wdata;
            trs80_io_pkg::PORT_CASS:    cass_reg <= bus.wdata;
            default: ;
         endcase
      end
   end

   // rtc latch, a read of ec acknowledges
   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
         rtc_int <= 1'b0;
      else if (bus.rd && bus.port == trs80_io_pkg::PORT_MOD_RTC)
         rtc_int <= 1'b0;   // ack wins over a new tick
      else if (rtc_tick)
         rtc_int <= 1'b1;
   end

   // 0 means active in the status byte
   assign int_stat = ~(8'(rtc_int) << trs80_io_pkg::INT_RTC_BIT);

   always_comb
   begin
      case (bus.port)
         trs80_io_pkg::PORT_INT:  sys_rdata = int_stat;
         trs80_io_pkg::PORT_CASS: sys_rdata = {cass_in, mod_reg[6:1], 1'b0};   // model 4 layout
         default:                 sys_rdata = 8'hff;   // opreg and ec read back nothing
      endcase
   end

   assign int_n        = ~(rtc_int & int_mask[trs80_io_pkg::INT_RTC_BIT]);
   assign cpu_fast     = mod_reg[trs80_io_pkg::MOD_CPUFAST];
   assign cass_out     = {~cass_reg[1], cass_reg[0]};
   assign cass_out_sel = bus.wr & (bus.port == trs80_io_pkg::PORT_CASS);

endmodule

//--- rtc_timer.sv
`timescale 1ns/1ns

module rtc_timer (
   input  logic z80_clk,
   input  logic z80_rst_n,
   input  logic cpu_fast,
   output logic rtc_tick
);

   logic [7:0] cnt;
   logic [7:0] period;

   assign period = cpu_fast ? trs80_io_pkg::RTC_PERIOD_FAST : trs80_io_pkg::RTC_PERIOD_SLOW;

   // tick is high while cnt sits at zero, not right after reset
   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
      begin
         cnt      <= 8'd0;
         rtc_tick <= 1'b0;
      end
      else if (cnt == 8'd0 || cnt >= period)
      begin
         cnt      <= period - 8'd1;   // reload, also cuts a slow count on speed change
         rtc_tick <= 1'b0;
      end
      else
      begin
         cnt      <= cnt - 8'd1;
         rtc_tick <= (cnt == 8'd1);
      end
   end

endmodule

//--- hires_xy_fsm.sv
`timescale 1ns/1ns

module hires_xy_fsm (
   input  logic z80_clk,
   input  logic z80_rst_n,
   z80_io_if.periph bus,
   output logic [trs80_io_pkg::HIRES_ADDR_W-1:0] hires_addr,
   output logic hires_we,
   output logic is_hires
);

   logic [7:0] x_reg;     // column byte, 0-127 used
   logic [7:0] y_reg;     // row
   logic [7:0] opt_reg;
   trs80_io_pkg::hires_state_t state;
   logic data_sel;        // data port access in progress
   logic leave;           // access just ended
   logic x_step, y_step;
   logic [7:0] x_delta, y_delta;

   assign data_sel = (bus.port == trs80_io_pkg::PORT_HIRES_DATA);
   assign leave    = (state != trs80_io_pkg::HIRES_IDLE) & ~data_sel;

   // hold bits depend on the access type recorded
   always_comb
   begin
      if (state == trs80_io_pkg::HIRES_RD_PEND)
      begin
         x_step = ~opt_reg[trs80_io_pkg::OPT_X_RD_HOLD];
         y_step = ~opt_reg[trs80_io_pkg::OPT_Y_RD_HOLD];
      end
      else
      begin
         x_step = ~opt_reg[trs80_io_pkg::OPT_X_WR_HOLD];
         y_step = ~opt_reg[trs80_io_pkg::OPT_Y_WR_HOLD];
      end
   end

   assign x_delta = opt_reg[trs80_io_pkg::OPT_X_DEC] ? 8'hff : 8'h01;   // -1 or +1, wraps
   assign y_delta = opt_reg[trs80_io_pkg::OPT_Y_DEC] ? 8'hff : 8'h01;

   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
         state <= trs80_io_pkg::HIRES_IDLE;
      else
      begin
         case (state)
            trs80_io_pkg::HIRES_IDLE:
               if (data_sel)
                  state <= bus.wr ? trs80_io_pkg::HIRES_WR_PEND : trs80_io_pkg::HIRES_RD_PEND;
            default:
               if (!data_sel)
                  state <= trs80_io_pkg::HIRES_IDLE;   // post-modify happens here
         endcase
      end
   end

   // register writes beat a pending step
   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
      begin
         x_reg   <= 8'h00;
         y_reg   <= 8'h00;
         opt_reg <= 8'h00;
      end
      else
      begin
         if (bus.wr && bus.port == trs80_io_pkg::PORT_HIRES_X)
            x_reg <= bus.wdata;
         else if (leave && x_step)
            x_reg <= x_reg + x_delta;

         if (bus.wr && bus.port == trs80_io_pkg::PORT_HIRES_Y)
            y_reg <= bus.wdata;
         else if (leave && y_step)
            y_reg <= y_reg + y_delta;

         if (bus.wr && bus.port == trs80_io_pkg::PORT_HIRES_OPT)
            opt_reg <= bus.wdata;
      end
   end

   assign hires_addr = {x_reg[6:0], y_reg};
   assign hires_we   = bus.wr & data_sel;
   assign is_hires   = opt_reg[trs80_io_pkg::OPT_GRAPHICS];

endmodule

//--- hires_ram.sv
`timescale 1ns/1ns

module hires_ram (
   input  logic z80_clk,
   input  logic [trs80_io_pkg::HIRES_ADDR_W-1:0] hires_addr,
   input  logic hires_we,
   input  logic [trs80_io_pkg::BYTE_W-1:0] wdata,
   output logic [trs80_io_pkg::BYTE_W-1:0] hires_rdata
);

   localparam int DEPTH = 1 << trs80_io_pkg::HIRES_ADDR_W;   // 32 KB

   logic [trs80_io_pkg::BYTE_W-1:0] mem [DEPTH];

   // cpu port only, video side dropped
   always_ff @(posedge z80_clk)
   begin
      if (hires_we)
         mem[hires_addr] <= wdata;
   end

   // async read so data is ready in the strobe cycle
   assign hires_rdata = mem[hires_addr];

endmodule

//--- orch90_dac.sv
`timescale 1ns/1ns

module orch90_dac (
   input  logic z80_clk,
   input  logic z80_rst_n,
   z80_io_if.periph bus,
   output logic orch90l_out,
   output logic orch90r_out
);

   logic [7:0] sample [2];   // 0 left, 1 right
   logic [7:0] acc [2];      // first order pdm accumulators
   logic [1:0] pdm;          // registered carries
   logic [1:0] load;

   assign load[0] = bus.wr & (bus.port == trs80_io_pkg::PORT_ORCH_L);
   assign load[1] = bus.wr & (bus.port == trs80_io_pkg::PORT_ORCH_R);

   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
      begin
         for (int ch = 0; ch < 2; ch++)
         begin
            sample[ch] <= 8'h00;
            acc[ch]    <= 8'h00;
         end
         pdm <= 2'b00;
      end
      else
      begin
         for (int ch = 0; ch < 2; ch++)
         begin
            if (load[ch])
               sample[ch] <= bus.wdata;
            // signed sample to offset binary, carry is the pulse
            {pdm[ch], acc[ch]} <= {1'b0, acc[ch]} + {1'b0, sample[ch] ^ 8'h80};
         end
      end
   end

   assign orch90l_out = pdm[0];
   assign orch90r_out = pdm[1];

endmodule

//--- trs80_io.sv
`timescale 1ns/1ns

module trs80_io (
   input  logic z80_clk,
   input  logic z80_rst_n,
   input  logic [7:0] io_addr,
   input  logic [7:0] io_wdata,
   input  logic iorq_n,
   input  logic rd_n,
   input  logic wr_n,
   input  logic cass_in,
   output logic [7:0] io_rdata,
   output logic int_n,
   output logic cpu_fast,
   output logic is_hires,
   output logic [1:0] cass_out,
   output logic cass_out_sel,
   output logic orch90l_out,
   output logic orch90r_out
);

   logic rtc_tick;
   logic [trs80_io_pkg::BYTE_W-1:0] sys_rdata;
   logic [trs80_io_pkg::BYTE_W-1:0] hires_rdata;
   logic [trs80_io_pkg::HIRES_ADDR_W-1:0] hires_addr;
   logic hires_we;

   z80_io_if io_if ();

   z80_io_bus u_z80_io_bus (
      .iorq_n      (iorq_n),
      .rd_n        (rd_n),
      .wr_n        (wr_n),
      .io_addr     (io_addr),
      .io_wdata    (io_wdata),
      .sys_rdata   (sys_rdata),
      .hires_rdata (hires_rdata),
      .io_rdata    (io_rdata),
      .bus         (io_if.bus)
   );

   system_ctrl_regs u_system_ctrl_regs (
      .z80_clk      (z80_clk),
      .z80_rst_n    (z80_rst_n),
      .rtc_tick     (rtc_tick),
      .cass_in      (cass_in),
      .bus          (io_if.periph),
      .sys_rdata    (sys_rdata),
      .int_n        (int_n),
      .cpu_fast     (cpu_fast),
      .cass_out_sel (cass_out_sel),
      .cass_out     (cass_out)
   );

   // rtc rate follows the cpu speed bit
   rtc_timer u_rtc_timer (
      .z80_clk   (z80_clk),
      .z80_rst_n (z80_rst_n),
      .cpu_fast  (cpu_fast),
      .rtc_tick  (rtc_tick)
   );

   hires_xy_fsm u_hires_xy_fsm (
      .z80_clk    (z80_clk),
      .z80_rst_n  (z80_rst_n),
      .bus        (io_if.periph),
      .hires_addr (hires_addr),
      .hires_we   (hires_we),
      .is_hires   (is_hires)
   );

   hires_ram u_hires_ram (
      .z80_clk     (z80_clk),
      .hires_addr  (hires_addr),
      .hires_we    (hires_we),
      .wdata       (io_if.wdata),
      .hires_rdata (hires_rdata)
   );

   orch90_dac u_orch90_dac (
      .z80_clk     (z80_clk),
      .z80_rst_n   (z80_rst_n),
      .bus         (io_if.periph),
      .orch90l_out (orch90l_out),
      .orch90r_out (orch90r_out)
   );

endmodule

//--- tb_trs80_io.sv
`timescale 1ns/1ns

module tb_trs80_io;

   localparam int MAX_CYCLES = 4000;   // well above the summed test lengths

   logic z80_clk;
   logic z80_rst_n;
   logic [7:0] io_addr;
   logic [7:0] io_wdata;
   logic iorq_n;
   logic rd_n;
   logic wr_n;
   logic cass_in;
   logic [7:0] io_rdata;
   logic int_n;
   logic cpu_fast;
   logic is_hires;
   logic [1:0] cass_out;
   logic cass_out_sel;
   logic orch90l_out;
   logic orch90r_out;

   logic [15:0] lfsr_q = 16'd25;
   int cycle_cnt = 0;
   int err_count = 0;
   int check_count = 0;
   int test_errs = 0;     // errors at start of current test
   int tests_run = 0;
   int tests_failed = 0;

   trs80_io u_trs80_io (
      .z80_clk      (z80_clk),
      .z80_rst_n    (z80_rst_n),
      .io_addr      (io_addr),
      .io_wdata     (io_wdata),
      .iorq_n       (iorq_n),
      .rd_n         (rd_n),
      .wr_n         (wr_n),
      .cass_in      (cass_in),
      .io_rdata     (io_rdata),
      .int_n        (int_n),
      .cpu_fast     (cpu_fast),
      .is_hires     (is_hires),
      .cass_out     (cass_out),
      .cass_out_sel (cass_out_sel),
      .orch90l_out  (orch90l_out),
      .orch90r_out  (orch90r_out)
   );

   always #20 z80_clk = ~z80_clk;

   always @(posedge z80_clk)
      cycle_cnt <= cycle_cnt + 1;

   // taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic rand_bit();
      lfsr_q = lfsr_next(lfsr_q);
      return lfsr_q[0];
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [7:0] b;
      b = 8'h00;
      for (int i = 0; i < 8; i++)
         b = {b[6:0], rand_bit()};
      return b;
   endfunction

   // strobe one cycle, idle one cycle, return on a negedge
   task automatic io_write(input logic [7:0] addr, input logic [7:0] data);
      @(posedge z80_clk);
      io_addr  <= addr;
      io_wdata <= data;
      iorq_n   <= 1'b0;
      wr_n     <= 1'b0;
      @(posedge z80_clk);   // register takes data here
      iorq_n <= 1'b1;
      wr_n   <= 1'b1;
      @(negedge z80_clk);
   endtask

   task automatic io_read(input logic [7:0] addr, output logic [7:0] data);
      @(posedge z80_clk);
      io_addr <= addr;
      iorq_n  <= 1'b0;
      rd_n    <= 1'b0;
      @(negedge z80_clk);
      data = io_rdata;      // mid strobe, stable
      @(posedge z80_clk);
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      @(negedge z80_clk);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge z80_clk);
   endtask

   task automatic check_value(input string name, input logic [15:0] exp,
                              input logic [15:0] got);
      check_count++;
      assert (got === exp)
      else
      begin
         $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
         err_count++;
      end
   endtask

   task automatic wait_int_low(input int limit);
      int n;
      n = 0;
      while (int_n !== 1'b0 && n < limit)
      begin
         @(negedge z80_clk);
         n++;
      end
      check_count++;
      assert (int_n === 1'b0)
      else
      begin
         $display("int_n did not fall within %0d cycles at %0t ns", limit, $time);
         err_count++;
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (err_count == test_errs)
         $display("test %s passed", name);
      else
      begin
         $display("test %s failed with %0d errors", name, err_count - test_errs);
         tests_failed++;
      end
      test_errs = err_count;
   endtask

   // fc-ff write strobe shows on cass_out_sel in the same cycle
   always @(negedge z80_clk)
   begin
      if (z80_rst_n)
         check_value("cass_out_sel", 16'(!iorq_n && !wr_n && io_addr >= 8'hfc),
                     16'(cass_out_sel));
   end

   initial
   begin : watchdog
      wait (cycle_cnt >= MAX_CYCLES);
      $display("run timed out after %0d cycles", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
   end

   initial
   begin : stimulus
      logic [7:0] rd;
      logic [7:0] ec_val, fc_val;
      logic cass_bit;
      logic [7:0] x0, y0, xb;
      logic [7:0] row_data [4];
      logic [7:0] smp_l, smp_r;
      int ones_l, ones_r;

      z80_clk   = 1'b0;
      z80_rst_n = 1'b0;
      io_addr   = 8'h00;
      io_wdata  = 8'h00;
      iorq_n    = 1'b1;
      rd_n      = 1'b1;
      wr_n      = 1'b1;
      cass_in   = 1'b0;
      repeat (2) @(posedge z80_clk);
      z80_rst_n <= 1'b1;
      @(negedge z80_clk);

      // reset values
      check_value("int_n", 16'h1, int_n);
      check_value("cass_out", 16'h2, cass_out);
      check_value("cpu_fast", 16'h0, cpu_fast);
      check_value("is_hires", 16'h0, is_hires);
      check_value("cass_out_sel", 16'h0, cass_out_sel);
      io_read(8'he0, rd);
      check_value("io_rdata e0", 16'hff, rd);
      finish_test("reset");

      // mode and cassette registers
      ec_val   = rand_byte();
      fc_val   = rand_byte();
      cass_bit = rand_bit();
      io_write(8'hec, ec_val);
      check_value("cpu_fast", 16'(ec_val[6]), cpu_fast);
      io_write(8'hfc, fc_val);
      check_value("cass_out", 16'({~fc_val[1], fc_val[0]}), cass_out);
      @(posedge z80_clk);
      cass_in <= cass_bit;
      io_read(8'hfc, rd);
      check_value("io_rdata fc", 16'({cass_bit, ec_val[6:1], 1'b0}), rd);
      io_read(8'h10, rd);   // nothing lives here
      check_value("io_rdata 10", 16'hff, rd);
      finish_test("registers");

      // rtc interrupt, slow then fast
      io_write(8'hec, 8'h00);
      io_write(8'he0, 8'h04);
      wait_int_low(int'(trs80_io_pkg::RTC_PERIOD_SLOW) + 4);
      io_read(8'he0, rd);
      check_value("io_rdata e0", 16'(8'hff ^ (8'h01 << trs80_io_pkg::INT_RTC_BIT)), rd);
      io_read(8'hec, rd);   // ack
      check_value("int_n", 16'h1, int_n);
      io_write(8'hec, 8'h40);
      check_value("cpu_fast", 16'h1, cpu_fast);
      wait_int_low(int'(trs80_io_pkg::RTC_PERIOD_FAST) + 4);
      io_read(8'hec, rd);
      finish_test("rtc");

      // hi-res, diagonal writes with both axes stepping
      io_write(8'h83, 8'h00);
      check_value("is_hires", 16'h0, is_hires);
      x0 = rand_byte();
      y0 = rand_byte();
      io_write(8'h80, x0);
      io_write(8'h81, y0);
      for (int k = 0; k < 4; k++)
         io_write(8'h82, rand_byte());
      idle_cycles(1);   // last step lands one cycle after the strobe
      check_value("hires_addr", 16'({7'(x0 + 8'd4), 8'(y0 + 8'd4)}),
                  u_trs80_io.hires_addr);
      // one row at the final y, y held on writes
      io_write(8'h83, 8'h80);
      for (int k = 0; k < 4; k++)
      begin
         row_data[k] = rand_byte();
         io_write(8'h82, row_data[k]);
      end
      idle_cycles(1);
      check_value("hires_addr", 16'({7'(x0 + 8'd8), 8'(y0 + 8'd4)}),
                  u_trs80_io.hires_addr);
      // read back right to left, y held on reads
      xb = x0 + 8'd7;
      io_write(8'h80, xb);
      io_write(8'h83, 8'h24);
      check_value("is_hires", 16'h0, is_hires);
      for (int k = 0; k < 4; k++)
      begin
         io_read(8'h82, rd);
         check_value("io_rdata 82", 16'(row_data[3 - k]), rd);
      end
      idle_cycles(1);
      check_value("hires_addr", 16'({7'(xb - 8'd4), 8'(y0 + 8'd4)}),
                  u_trs80_io.hires_addr);
      io_write(8'h83, 8'h01);   // graphics on
      check_value("is_hires", 16'h1, is_hires);
      finish_test("hires");

      // pdm duty over one full accumulator cycle
      smp_l = rand_byte();
      smp_r = rand_byte();
      io_write(8'h75, smp_l);
      io_write(8'h79, smp_r);
      idle_cycles(4);
      ones_l = 0;
      ones_r = 0;
      repeat (256)
      begin
         @(negedge z80_clk);
         ones_l += int'(orch90l_out);
         ones_r += int'(orch90r_out);
      end
      check_value("orch90l_out ones", 16'(smp_l ^ 8'h80), 16'(ones_l));
      check_value("orch90r_out ones", 16'(smp_r ^ 8'h80), 16'(ones_r));
      finish_test("orch90");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, check_count, err_count);
      if (err_count == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

//--- trs80_io.f
trs80_io_pkg.sv
z80_io_if.sv
z80_io_bus.sv
system_ctrl_regs.sv
rtc_timer.sv
hires_xy_fsm.sv
hires_ram.sv
orch90_dac.sv
trs80_io.sv
tb_trs80_io.sv

//--- Bender.yml
package:
  name: trs80_io

sources:
  - trs80_io_pkg.sv
  - z80_io_if.sv
  - z80_io_bus.sv
  - system_ctrl_regs.sv
  - rtc_timer.sv
  - hires_xy_fsm.sv
  - hires_ram.sv
  - orch90_dac.sv
  - trs80_io.sv
  - target: test
    files:
      - tb_trs80_io.sv
